/* rv_core.f */
logic/rv_core_pkg.sv
logic/fetch_stage.sv
logic/register_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/memory_writeback.sv
logic/rv_core.sv
tests/rv_core_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= rv_core_tb
FILELIST ?= rv_core.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing -j 0
PASS_TEXT ?= *** TEST PASSED ***

.PHONY: simulate clean

simulate:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* tests/rv_core_tb.sv */
`timescale 1ns/1ps

module rv_core_tb import rv_core_pkg::*; ();

	localparam word_t marker_addr = 32'h0000_03fc;
	localparam int max_cycles = 2000;
	localparam int drain_cycles = 8;

	logic clock = 1'b0;
	logic reset;
	logic mem_ready = 1'b1;
	logic random_mode;
	word_t pc, data_addr, data_wdata, data_rdata;
	instr_t instr;
	logic read_en, write_en;

	instr_t prog [64];
	int next_slot;
	word_t dmem [256];
	int write_count [256];
	logic marker_seen;
	int errors = 0;
	int checks = 0;

	rv_core rv_core_inst (
		.clock(clock),
		.reset(reset),
		.pc(pc),
		.instr(instr),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.data_rdata(data_rdata),
		.read_en(read_en),
		.write_en(write_en),
		.mem_ready(mem_ready)
	);

	always #5 clock = ~clock;

	//////////////////////////////////////////////////
	// memory models
	//////////////////////////////////////////////////
	// instruction fetch answers in the same cycle
	assign instr = (pc < 32'd256) ? prog[pc[7:2]] : nop_instr;
	assign data_rdata = read_en ? dmem[data_addr[9:2]] : '0;

	function automatic word_t fill_value(input logic [7:0] idx);
		word_t addr;
		addr = {22'b0, idx, 2'b00};
		return (addr << 20) ^ (addr * 32'h0001_0003) ^ 32'h3c5a_0f00;
	endfunction

	always @(posedge clock) begin
		mem_ready <= random_mode ? (($urandom & 32'd1) != 0) : 1'b1;
	end

	// data memory reloads its fill pattern while reset is low
	always @(posedge clock) begin
		if (!reset) begin
			for (int i = 0; i < 256; i++) begin
				dmem[i] <= fill_value(8'(i));
				write_count[i] <= 0;
			end
			marker_seen <= 1'b0;
		end else if (write_en && mem_ready) begin
			dmem[data_addr[9:2]] <= data_wdata;
			write_count[data_addr[9:2]] <= write_count[data_addr[9:2]] + 1;
			if (data_addr == marker_addr) begin
				marker_seen <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// instruction encoders
	//////////////////////////////////////////////////
	function automatic instr_t r_op(input int funct7, input int funct3, input int rd,
		input int rs1, input int rs2);
		return {funct7[6:0], rs2[4:0], rs1[4:0], funct3[2:0], rd[4:0], op_rtype};
	endfunction

	function automatic instr_t addi(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], op_itype};
	endfunction

	function automatic instr_t lw(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b010, rd[4:0], op_load};
	endfunction

	function automatic instr_t sw(input int rs2, input int rs1, input int imm);
		return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], op_store};
	endfunction

	function automatic instr_t beq(input int rs1, input int rs2, input int imm);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], 3'b000, imm[4:1], imm[11], op_branch};
	endfunction

	function automatic instr_t jal(input int rd, input int imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], op_jal};
	endfunction

	//////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////
	task automatic clear_program();
		for (int i = 0; i < 64; i++) begin
			prog[i] = nop_instr;
		end
		next_slot = 0;
	endtask

	task automatic emit(input instr_t word);
		prog[next_slot] = word;
		next_slot++;
	endtask

	// three edges in reset, memories reload meanwhile
	task automatic start_program(input logic random_ready);
		@(posedge clock);
		reset <= 1'b0;
		random_mode <= random_ready;
		repeat (3) @(posedge clock);
		reset <= 1'b1;
	endtask

	task automatic wait_for_marker(input string name);
		int cycles;
		cycles = 0;
		while (!marker_seen && cycles < max_cycles) begin
			@(posedge clock);
			cycles++;
		end
		if (!marker_seen) begin
			errors++;
			$display("timeout: %s never stored to the marker address within %0d cycles",
				name, max_cycles);
		end else begin
			// let the pipeline drain so a repeated store still gets counted
			repeat (drain_cycles) @(posedge clock);
		end
	endtask

	task automatic expect_word(input word_t addr, input word_t expected, input string what);
		checks++;
		assert (dmem[addr[9:2]] == expected) else begin
			errors++;
			$display("ERROR @%0t: %s at 0x%08h is 0x%08h, expected 0x%08h",
				$time, what, addr, dmem[addr[9:2]], expected);
		end
	endtask

	task automatic written_once(input word_t addr, input string what);
		checks++;
		assert (write_count[addr[9:2]] == 1) else begin
			errors++;
			$display("ERROR @%0t: %s at 0x%08h written %0d times, expected once",
				$time, what, addr, write_count[addr[9:2]]);
		end
	endtask

	//////////////////////////////////////////////////
	// directed tests
	//////////////////////////////////////////////////
	// back-to-back dependencies, every operand forwarded
	task automatic alu_chain_test(input logic random_ready);
		word_t r [10];
		string name;
		name = random_ready ? "alu chain with random ready" : "alu chain";
		r[1] = 23;
		r[2] = -7;
		r[3] = r[1] + r[2];
		r[4] = r[3] - r[1];
		r[5] = r[4] & r[3];
		r[6] = r[5] | r[1];
		r[7] = r[6] ^ r[4];
		r[8] = ($signed(r[7]) < $signed(r[3])) ? 1 : 0;
		r[9] = r[8] + 100;
		clear_program();
		emit(addi(1, 0, 23));
		emit(addi(2, 0, -7));
		emit(r_op(0, 0, 3, 1, 2));
		emit(r_op(32, 0, 4, 3, 1));
		emit(r_op(0, 7, 5, 4, 3));
		emit(r_op(0, 6, 6, 5, 1));
		emit(r_op(0, 4, 7, 6, 4));
		emit(r_op(0, 2, 8, 7, 3));
		emit(addi(9, 8, 100));
		for (int k = 3; k <= 9; k++) begin
			emit(sw(k, 0, 32'h100 + 4 * (k - 3)));
		end
		emit(sw(0, 0, marker_addr));
		start_program(random_ready);
		wait_for_marker(name);
		for (int k = 3; k <= 9; k++) begin
			expect_word(32'h100 + 4 * (k - 3), r[k], name);
			written_once(32'h100 + 4 * (k - 3), name);
		end
		written_once(marker_addr, name);
	endtask

	task automatic load_use_test();
		clear_program();
		emit(addi(5, 0, 37));
		emit(lw(2, 0, 32'h80));
		emit(r_op(0, 0, 3, 2, 5));
		emit(sw(3, 0, 32'h120));
		emit(sw(0, 0, marker_addr));
		start_program(1'b0);
		wait_for_marker("load use");
		expect_word(32'h120, fill_value(8'd32) + 32'd37, "load use sum");
	endtask

	// x5 gets poisoned only if a squash fails
	task automatic control_flow_test();
		clear_program();
		emit(addi(5, 0, 11));
		emit(beq(0, 0, 12));
		emit(addi(5, 0, -1));
		emit(addi(5, 0, -1));
		emit(jal(6, 12));
		emit(addi(5, 0, -1));
		emit(addi(5, 0, -1));
		emit(sw(5, 0, 32'h108));
		emit(sw(6, 0, 32'h10c));
		emit(sw(0, 0, marker_addr));
		start_program(1'b0);
		wait_for_marker("taken beq and jal");
		expect_word(32'h108, 32'd11, "register after squash");
		// jal sits at pc 16
		expect_word(32'h10c, 32'd16 + 32'd4, "jal link");
	endtask

	task automatic fall_through_test();
		clear_program();
		emit(addi(1, 0, 5));
		emit(addi(2, 0, 6));
		emit(beq(1, 2, 12));
		emit(addi(3, 0, 77));
		emit(addi(4, 3, 1));
		emit(sw(3, 0, 32'h110));
		emit(sw(4, 0, 32'h114));
		emit(sw(0, 0, marker_addr));
		start_program(1'b0);
		wait_for_marker("beq not taken");
		expect_word(32'h110, 32'd77, "fall through first");
		expect_word(32'h114, 32'd78, "fall through second");
	endtask

	initial begin
		reset = 1'b0;
		random_mode = 1'b0;
		void'($urandom(32'ha41cbde9));
		clear_program();
		alu_chain_test(1'b0);
		load_use_test();
		control_flow_test();
		fall_through_test();
		alu_chain_test(1'b1);
		$display("summary: %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* logic/rv_core.sv */
`timescale 1ns/1ps

module rv_core import rv_core_pkg::*; (
	input logic clock,
	input logic reset,
	output word_t pc,
	input instr_t instr,
	output word_t data_addr,
	output word_t data_wdata,
	input word_t data_rdata,
	output logic read_en,
	output logic write_en,
	input logic mem_ready
);

	if_id_t if_id;
	id_ex_t id_ex;
	ex_mem_t ex_mem;
	wb_t wb;
	redirect_t redirect;
	logic load_use_stall;
	logic mem_stall;
	reg_addr_t rs1_addr, rs2_addr;
	word_t rs1_data, rs2_data;

	//////////////////////////////////////////////////
	// front end
	//////////////////////////////////////////////////
	fetch_stage fetch_inst (
		.clock(clock),
		.reset(reset),
		.instr(instr),
		.redirect(redirect),
		.load_use_stall(load_use_stall),
		.mem_stall(mem_stall),
		.pc(pc),
		.if_id(if_id)
	);

	decode_stage decode_inst (
		.clock(clock),
		.reset(reset),
		.if_id(if_id),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.redirect(redirect),
		.mem_stall(mem_stall),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.load_use_stall(load_use_stall),
		.id_ex(id_ex)
	);

	register_file regfile_inst (
		.clock(clock),
		.reset(reset),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.wb(wb),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data)
	);

	//////////////////////////////////////////////////
	// back end
	//////////////////////////////////////////////////
	execute_stage execute_inst (
		.clock(clock),
		.reset(reset),
		.id_ex(id_ex),
		.wb(wb),
		.mem_stall(mem_stall),
		.ex_mem(ex_mem),
		.redirect(redirect)
	);

	memory_writeback memwb_inst (
		.clock(clock),
		.reset(reset),
		.ex_mem(ex_mem),
		.data_rdata(data_rdata),
		.mem_ready(mem_ready),
		.data_addr(data_addr),
		.data_wdata(data_wdata),
		.read_en(read_en),
		.write_en(write_en),
		.mem_stall(mem_stall),
		.wb(wb)
	);

endmodule

/* logic/memory_writeback.sv */
`timescale 1ns/1ps

module memory_writeback import rv_core_pkg::*; (
	input logic clock,
	input logic reset,
	input ex_mem_t ex_mem,
	input word_t data_rdata,
	input logic mem_ready,
	output word_t data_addr,
	output word_t data_wdata,
	output logic read_en,
	output logic write_en,
	output logic mem_stall,
	output wb_t wb
);

	word_t wb_data;

	// data port straight from EX/MEM, stable while the access waits
	assign data_addr = ex_mem.result;
	assign data_wdata = ex_mem.store_data;
	assign read_en = ex_mem.valid && ex_mem.is_load;
	assign write_en = ex_mem.valid && ex_mem.is_store;

	// whole pipeline freezes until the access completes
	assign mem_stall = (read_en || write_en) && !mem_ready;

	// load data is sampled in the completing cycle
	assign wb_data = ex_mem.is_load ? data_rdata : ex_mem.result;

	// MEM/WB keeps its entry through a stall, so the frozen EX stage
	// still sees the forwarded value it was relying on
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			wb.reg_write <= 1'b0;
		end else if (!mem_stall) begin
			wb <= '{
				reg_write: ex_mem.valid && ex_mem.reg_write,
				rd: ex_mem.rd,
				data: wb_data
			};
		end
	end

endmodule

/* logic/execute_stage.sv */
`timescale 1ns/1ps

module execute_stage import rv_core_pkg::*; (
	input logic clock,
	input logic reset,
	input id_ex_t id_ex,
	input wb_t wb,
	input logic mem_stall,
	output ex_mem_t ex_mem,
	output redirect_t redirect
);

	word_t operand_a, operand_b, alu_b;
	word_t alu_result, ex_result;

	// younger producer in EX/MEM wins over writeback
	function automatic word_t forward(reg_addr_t rs, word_t reg_value, ex_mem_t mem_entry,
		wb_t wb_entry);
		word_t value;
		value = reg_value;
		if (rs != '0) begin
			if (mem_entry.valid && mem_entry.reg_write && mem_entry.rd == rs) begin
				value = mem_entry.result;
			end else if (wb_entry.reg_write && wb_entry.rd == rs) begin
				value = wb_entry.data;
			end
		end
		return value;
	endfunction

	assign operand_a = forward(id_ex.rs1, id_ex.rs1_data, ex_mem, wb);
	assign operand_b = forward(id_ex.rs2, id_ex.rs2_data, ex_mem, wb);
	assign alu_b = id_ex.use_imm ? id_ex.imm : operand_b;

	//////////////////////////////////////////////////
	// ALU
	//////////////////////////////////////////////////
	always_comb begin
		case (id_ex.alu_op)
			alu_add: alu_result = operand_a + alu_b;
			alu_sub: alu_result = operand_a - alu_b;
			alu_and: alu_result = operand_a & alu_b;
			alu_or: alu_result = operand_a | alu_b;
			alu_xor: alu_result = operand_a ^ alu_b;
			alu_slt: alu_result = {31'b0, $signed(operand_a) < $signed(alu_b)};
			default: alu_result = operand_a + alu_b;
		endcase
	end

	// jal links pc + 4
	assign ex_result = id_ex.is_jump ? id_ex.pc + 32'd4 : alu_result;

	// resolved here, two younger instructions get squashed
	assign redirect.taken = id_ex.valid
		&& (id_ex.is_jump || (id_ex.is_branch && operand_a == operand_b));
	assign redirect.target = id_ex.pc + id_ex.imm;

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			ex_mem.valid <= 1'b0;
		end else if (!mem_stall) begin
			ex_mem <= '{
				valid: id_ex.valid,
				result: ex_result,
				store_data: operand_b,
				rd: id_ex.rd,
				is_load: id_ex.is_load,
				is_store: id_ex.is_store,
				reg_write: id_ex.reg_write
			};
		end
	end

endmodule

/* logic/decode_stage.sv */
`timescale 1ns/1ps

module decode_stage import rv_core_pkg::*; (
	input logic clock,
	input logic reset,
	input if_id_t if_id,
	input word_t rs1_data,
	input word_t rs2_data,
	input redirect_t redirect,
	input logic mem_stall,
	output reg_addr_t rs1_addr,
	output reg_addr_t rs2_addr,
	output logic load_use_stall,
	output id_ex_t id_ex
);

	opcode_t opcode;
	logic [2:0] funct3;
	logic alt_op;
	word_t imm_i, imm_s, imm_b, imm_j;
	id_ex_t decoded;

	assign opcode = if_id.instr[6:0];
	assign funct3 = if_id.instr[14:12];
	// funct7 bit 5 separates sub from add
	assign alt_op = if_id.instr[30];
	assign rs1_addr = if_id.instr[19:15];
	assign rs2_addr = if_id.instr[24:20];

	//////////////////////////////////////////////////
	// immediates
	//////////////////////////////////////////////////
	assign imm_i = {{20{if_id.instr[31]}}, if_id.instr[31:20]};
	assign imm_s = {{20{if_id.instr[31]}}, if_id.instr[31:25], if_id.instr[11:7]};
	assign imm_b = {{19{if_id.instr[31]}}, if_id.instr[31], if_id.instr[7],
		if_id.instr[30:25], if_id.instr[11:8], 1'b0};
	assign imm_j = {{11{if_id.instr[31]}}, if_id.instr[31], if_id.instr[19:12],
		if_id.instr[20], if_id.instr[30:21], 1'b0};

	// control decode, unknown opcodes fall through as a nop
	always_comb begin
		decoded = '0;
		decoded.valid = if_id.valid;
		decoded.pc = if_id.pc;
		decoded.rs1 = rs1_addr;
		decoded.rs2 = rs2_addr;
		decoded.rd = if_id.instr[11:7];
		decoded.rs1_data = rs1_data;
		decoded.rs2_data = rs2_data;
		decoded.alu_op = alu_add;
		case (opcode)
			op_rtype: begin
				decoded.reg_write = 1'b1;
				case (funct3)
					3'b000: decoded.alu_op = alt_op ? alu_sub : alu_add;
					3'b010: decoded.alu_op = alu_slt;
					3'b100: decoded.alu_op = alu_xor;
					3'b110: decoded.alu_op = alu_or;
					3'b111: decoded.alu_op = alu_and;
					default: decoded.alu_op = alu_add;
				endcase
			end
			op_itype: begin
				decoded.imm = imm_i;
				decoded.use_imm = 1'b1;
				decoded.reg_write = 1'b1;
			end
			op_load: begin
				decoded.imm = imm_i;
				decoded.use_imm = 1'b1;
				decoded.is_load = 1'b1;
				decoded.reg_write = 1'b1;
			end
			op_store: begin
				decoded.imm = imm_s;
				decoded.use_imm = 1'b1;
				decoded.is_store = 1'b1;
			end
			op_branch: begin
				decoded.imm = imm_b;
				decoded.is_branch = 1'b1;
			end
			op_jal: begin
				decoded.imm = imm_j;
				decoded.is_jump = 1'b1;
				decoded.reg_write = 1'b1;
			end
			default: ;
		endcase
	end

	// load in EX whose result the instruction in ID needs
	assign load_use_stall = if_id.valid && id_ex.valid && id_ex.is_load && id_ex.rd != '0
		&& (id_ex.rd == rs1_addr || id_ex.rd == rs2_addr);

	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			id_ex.valid <= 1'b0;
		end else if (!mem_stall) begin
			if (redirect.taken || load_use_stall) begin
				id_ex.valid <= 1'b0;
			end else begin
				id_ex <= decoded;
			end
		end
	end

endmodule

/* logic/register_file.sv */
`timescale 1ns/1ps

module register_file import rv_core_pkg::*; (
	input logic clock,
	input logic reset,
	input reg_addr_t rs1_addr,
	input reg_addr_t rs2_addr,
	input wb_t wb,
	output word_t rs1_data,
	output word_t rs2_data
);

	word_t regs [32];

	// x0 is never written and stays at its reset value
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.reg_write && wb.rd != '0) begin
			regs[wb.rd] <= wb.data;
		end
	end

	// write-through so ID sees the value retiring this cycle
	assign rs1_data = (wb.reg_write && wb.rd != '0 && wb.rd == rs1_addr) ? wb.data
		: regs[rs1_addr];
	assign rs2_data = (wb.reg_write && wb.rd != '0 && wb.rd == rs2_addr) ? wb.data
		: regs[rs2_addr];

endmodule

/* logic/fetch_stage.sv */
`timescale 1ns/1ps

module fetch_stage import rv_core_pkg::*; (
	input logic clock,
	input logic reset,
	input instr_t instr,
	input redirect_t redirect,
	input logic load_use_stall,
	input logic mem_stall,
	output word_t pc,
	output if_id_t if_id
);

	word_t pc_plus4;

	assign pc_plus4 = pc + 32'd4;

	// pc and IF/ID move together
	// a memory stall freezes both, even with a pending redirect,
	// since EX keeps the branch until the stall clears
	always_ff @(posedge clock or negedge reset) begin
		if (!reset) begin
			pc <= reset_pc;
			if_id.valid <= 1'b0;
		end else if (!mem_stall) begin
			if (redirect.taken) begin
				pc <= redirect.target;
				// the instruction fetched this cycle is squashed
				if_id <= '{valid: 1'b0, pc: pc, instr: nop_instr};
			end else if (!load_use_stall) begin
				pc <= pc_plus4;
				if_id <= '{valid: 1'b1, pc: pc, instr: instr};
			end
		end
	end

endmodule

/* logic/rv_core_pkg.sv */
package rv_core_pkg;

	//////////////////////////////////////////////////
	// widths and basic types
	//////////////////////////////////////////////////
	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [31:0] instr_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [2:0] alu_op_t;
	typedef logic [6:0] opcode_t;

	localparam word_t reset_pc = 32'h0000_0000;
	// addi x0, x0, 0
	localparam instr_t nop_instr = 32'h0000_0013;

	// major opcodes of the supported subset
	localparam opcode_t op_rtype = 7'b0110011;
	localparam opcode_t op_itype = 7'b0010011;
	localparam opcode_t op_load = 7'b0000011;
	localparam opcode_t op_store = 7'b0100011;
	localparam opcode_t op_branch = 7'b1100011;
	localparam opcode_t op_jal = 7'b1101111;

	localparam alu_op_t alu_add = 3'd0;
	localparam alu_op_t alu_sub = 3'd1;
	localparam alu_op_t alu_and = 3'd2;
	localparam alu_op_t alu_or = 3'd3;
	localparam alu_op_t alu_xor = 3'd4;
	localparam alu_op_t alu_slt = 3'd5;

	//////////////////////////////////////////////////
	// pipeline registers
	//////////////////////////////////////////////////
	typedef struct packed {
		logic valid;
		word_t pc;
		instr_t instr;
	} if_id_t;

	typedef struct packed {
		logic valid;
		word_t pc;
		reg_addr_t rs1;
		reg_addr_t rs2;
		reg_addr_t rd;
		word_t rs1_data;
		word_t rs2_data;
		word_t imm;
		alu_op_t alu_op;
		logic use_imm;
		logic is_load;
		logic is_store;
		logic is_branch;
		logic is_jump;
		logic reg_write;
	} id_ex_t;

	typedef struct packed {
		logic valid;
		word_t result;
		word_t store_data;
		reg_addr_t rd;
		logic is_load;
		logic is_store;
		logic reg_write;
	} ex_mem_t;

	typedef struct packed {
		logic reg_write;
		reg_addr_t rd;
		word_t data;
	} wb_t;

	typedef struct packed {
		logic taken;
		word_t target;
	} redirect_t;

endpackage
